/* hdl/dcache_pkg.sv */
package dcache_pkg;

    // cpu side widths, addresses count words
    localparam int unsigned ADDR_W         = 32;
    localparam int unsigned WORD_W         = 32;

    // line geometry
    localparam int unsigned WORDS_PER_LINE = 4;
    localparam int unsigned OFFSET_W       = 2;

    // associativity and tree plru
    localparam int unsigned NUM_WAYS       = 4;
    localparam int unsigned WAY_W          = 2;
    localparam int unsigned PLRU_W         = NUM_WAYS - 1;

    typedef logic [WORD_W-1:0]                    word_t;
    typedef logic [WORD_W/8-1:0]                  word_sel_t;
    typedef logic [WORDS_PER_LINE*WORD_W-1:0]     line_t;
    typedef logic [WORDS_PER_LINE*WORD_W/8-1:0]   line_sel_t;
    typedef logic [ADDR_W-1:0]                    addr_t;
    typedef logic [ADDR_W-OFFSET_W-1:0]           line_addr_t;  // word address minus offset
    typedef logic [WAY_W-1:0]                     way_idx_t;
    typedef logic [PLRU_W-1:0]                    plru_t;

    // request held by the controller while it is served
    typedef struct packed {
        logic      we;
        addr_t     addr;
        word_sel_t sel;
        word_t     wdata;
    } cpu_req_t;

    // one transaction on the memory bus
    typedef struct packed {
        logic       we;
        line_addr_t addr;
        line_sel_t  sel;
        line_t      wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        INSTALL,
        WRITE_MEM
    } ctrl_state_t;

    typedef enum logic {
        MEM_IDLE,
        MEM_BUSY
    } mem_state_t;

endpackage

/* hdl/dcache_way_store.sv */
`timescale 1ns/1ps

module dcache_way_store
    import dcache_pkg::*;
#(
    parameter int unsigned NUM_SETS_LOG2 = 4,
    localparam int unsigned TAG_W = ADDR_W - OFFSET_W - NUM_SETS_LOG2
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,

    // read port, all ways of one set
    input  logic                              rd_en_i,
    input  logic [NUM_SETS_LOG2-1:0]          rd_index_i,

    // write port, one way at a time
    input  way_idx_t                          wr_way_i,
    input  logic                              wr_tag_en_i,
    input  logic                              wr_data_en_i,
    input  logic [NUM_SETS_LOG2-1:0]          wr_index_i,
    input  logic [TAG_W-1:0]                  wr_tag_i,
    input  line_t                             wr_line_i,
    input  line_sel_t                         wr_sel_i,

    output logic [NUM_WAYS-1:0][TAG_W-1:0]    rd_tags_o,
    output logic [NUM_WAYS-1:0]               rd_valid_o,
    output line_t [NUM_WAYS-1:0]              rd_lines_o
);

    localparam int unsigned NUM_SETS   = 2**NUM_SETS_LOG2;
    localparam int unsigned LINE_BYTES = $bits(line_sel_t);

    logic [TAG_W-1:0]    tag_mem  [NUM_WAYS][NUM_SETS];
    line_t               line_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0] valid_q  [NUM_SETS];  // one bit per way, packed per set

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        always_ff @(posedge clk_i) begin
            if (rd_en_i) begin
                rd_tags_o[w]  <= tag_mem[w][rd_index_i];
                rd_lines_o[w] <= line_mem[w][rd_index_i];
            end

            if (wr_tag_en_i && wr_way_i == way_idx_t'(w)) begin
                tag_mem[w][wr_index_i] <= wr_tag_i;
            end

            // byte enables let a write hit touch only its word
            if (wr_data_en_i && wr_way_i == way_idx_t'(w)) begin
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (wr_sel_i[b]) begin
                        line_mem[w][wr_index_i][b*8 +: 8] <= wr_line_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q    <= '{default: '0};
            rd_valid_o <= '0;
        end else begin
            if (rd_en_i) begin
                rd_valid_o <= valid_q[rd_index_i];
            end
            if (wr_tag_en_i) begin
                valid_q[wr_index_i][wr_way_i] <= 1'b1;  // installing a tag makes the line live
            end
        end
    end

    // a new tag always comes with its line, otherwise stale data would turn valid
    a_tag_with_data: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        wr_tag_en_i |-> wr_data_en_i
    );

endmodule

/* hdl/dcache_plru.sv */
`timescale 1ns/1ps

module dcache_plru
    import dcache_pkg::*;
#(
    parameter int unsigned NUM_SETS_LOG2 = 4
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic [NUM_SETS_LOG2-1:0] index_i,
    input  way_idx_t                 access_way_i,
    input  logic                     update_i,
    output way_idx_t                 victim_o
);

    localparam int unsigned NUM_SETS = 2**NUM_SETS_LOG2;

    plru_t age_q [NUM_SETS];
    plru_t age_cur;
    plru_t age_next;

    assign age_cur = age_q[index_i];

    // bit 0 picks the half, bit 1 or bit 2 picks the way inside it
    always_comb begin
        if (age_cur[0]) begin
            victim_o = {1'b1, age_cur[2]};
        end else begin
            victim_o = {1'b0, age_cur[1]};
        end
    end

    // point the tree away from the way just touched
    always_comb begin
        age_next    = age_cur;
        age_next[0] = ~access_way_i[1];
        if (access_way_i[1]) begin
            age_next[2] = ~access_way_i[0];
        end else begin
            age_next[1] = ~access_way_i[0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            age_q <= '{default: '0};
        end else if (update_i) begin
            age_q[index_i] <= age_next;
        end
    end

endmodule

/* hdl/dcache_mem_port.sv */
`timescale 1ns/1ps

module dcache_mem_port
    import dcache_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,

    // controller side
    input  logic       start_i,
    input  mem_req_t   req_i,
    output logic       done_o,
    output line_t      rdata_o,

    // memory bus
    output logic       mem_cyc_o,
    output logic       mem_stb_o,
    output logic       mem_we_o,
    output line_addr_t mem_addr_o,
    output line_sel_t  mem_sel_o,
    output line_t      mem_wdata_o,
    input  logic       mem_ack_i,
    input  line_t      mem_rdata_i
);

    mem_state_t state_q;
    mem_req_t   req_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= MEM_IDLE;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            unique case (state_q)
                MEM_IDLE: if (start_i) state_q <= MEM_BUSY;
                MEM_BUSY: begin
                    if (mem_ack_i) begin
                        state_q <= MEM_IDLE;  // cyc and stb drop next cycle
                        done_o  <= 1'b1;
                    end
                end
                default: state_q <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i && state_q == MEM_IDLE) begin
            req_q <= req_i;
        end
        if (state_q == MEM_BUSY && mem_ack_i && !req_q.we) begin
            rdata_o <= mem_rdata_i;  // refill line kept for the install cycle
        end
    end

    assign mem_cyc_o   = (state_q == MEM_BUSY);
    assign mem_stb_o   = (state_q == MEM_BUSY);
    assign mem_we_o    = (state_q == MEM_BUSY) && req_q.we;
    assign mem_addr_o  = req_q.addr;
    assign mem_sel_o   = req_q.sel;
    assign mem_wdata_o = req_q.wdata;

    // memory answers only a strobed cycle
    a_ack_in_cyc: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        mem_ack_i |-> mem_cyc_o && mem_stb_o
    );

    // the controller issues one transaction at a time
    a_no_start_busy: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        start_i |-> state_q == MEM_IDLE
    );

endmodule

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int unsigned NUM_SETS_LOG2 = 4,
    localparam int unsigned TAG_W = ADDR_W - OFFSET_W - NUM_SETS_LOG2
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,

    // cpu bus
    input  logic                              cpu_cyc_i,
    input  logic                              cpu_stb_i,
    input  cpu_req_t                          cpu_req_i,
    output logic                              cpu_ack_o,
    output word_t                             cpu_rdata_o,

    // way store
    output logic                              rd_en_o,
    output logic [NUM_SETS_LOG2-1:0]          rd_index_o,
    input  logic [NUM_WAYS-1:0][TAG_W-1:0]    rd_tags_i,
    input  logic [NUM_WAYS-1:0]               rd_valid_i,
    input  line_t [NUM_WAYS-1:0]              rd_lines_i,
    output way_idx_t                          wr_way_o,
    output logic                              wr_tag_en_o,
    output logic                              wr_data_en_o,
    output logic [NUM_SETS_LOG2-1:0]          wr_index_o,
    output logic [TAG_W-1:0]                  wr_tag_o,
    output line_t                             wr_line_o,
    output line_sel_t                         wr_sel_o,

    // replacement
    output logic [NUM_SETS_LOG2-1:0]          index_o,
    output way_idx_t                          access_way_o,
    output logic                              plru_update_o,
    input  way_idx_t                          victim_i,

    // memory port
    output logic                              mem_start_o,
    output mem_req_t                          mem_req_o,
    input  logic                              mem_done_i,
    input  line_t                             mem_rdata_i
);

    localparam int unsigned SEL_W = $bits(word_sel_t);

    ctrl_state_t               state_q, state_d;
    cpu_req_t                  req_q;

    logic [OFFSET_W-1:0]       req_offset;
    logic [NUM_SETS_LOG2-1:0]  req_index;
    logic [TAG_W-1:0]          req_tag;

    logic [NUM_WAYS-1:0]       way_hit;
    logic                      hit;
    way_idx_t                  hit_way;

    line_t                     line_wdata;  // cpu word placed at its offset
    line_sel_t                 line_wsel;

    function automatic word_t line_word(line_t line, logic [OFFSET_W-1:0] offset);
        return line[offset*WORD_W +: WORD_W];
    endfunction

    assign req_offset = req_q.addr[OFFSET_W-1:0];
    assign req_index  = req_q.addr[OFFSET_W +: NUM_SETS_LOG2];
    assign req_tag    = req_q.addr[ADDR_W-1 -: TAG_W];

    assign line_wdata = line_t'(req_q.wdata) << (WORD_W * req_offset);
    assign line_wsel  = line_sel_t'(req_q.sel) << (SEL_W * req_offset);

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
        assign way_hit[w] = rd_valid_i[w] && (rd_tags_i[w] == req_tag);
    end

    assign hit = |way_hit;

    always_comb begin
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    // store lookup uses the live bus address, writes use the held request
    assign rd_index_o = cpu_req_i.addr[OFFSET_W +: NUM_SETS_LOG2];
    assign wr_index_o = req_index;
    assign wr_tag_o   = req_tag;
    assign index_o    = req_index;

    // reads fetch the full line, writes carry one word
    assign mem_req_o = '{
        we:    req_q.we,
        addr:  req_q.addr[ADDR_W-1:OFFSET_W],
        sel:   req_q.we ? line_wsel : '1,
        wdata: line_wdata
    };

    always_comb begin
        state_d       = state_q;
        rd_en_o       = 1'b0;
        cpu_ack_o     = 1'b0;
        cpu_rdata_o   = line_word(rd_lines_i[hit_way], req_offset);
        wr_way_o      = hit_way;
        wr_tag_en_o   = 1'b0;
        wr_data_en_o  = 1'b0;
        wr_line_o     = line_wdata;
        wr_sel_o      = line_wsel;
        access_way_o  = hit_way;
        plru_update_o = 1'b0;
        mem_start_o   = 1'b0;

        unique case (state_q)
            IDLE: begin
                if (cpu_cyc_i && cpu_stb_i) begin
                    rd_en_o = 1'b1;
                    state_d = LOOKUP;
                end
            end

            LOOKUP: begin
                if (req_q.we) begin
                    mem_start_o = 1'b1;  // every write goes out to memory
                    state_d     = WRITE_MEM;
                    if (hit) begin
                        wr_data_en_o  = 1'b1;
                        plru_update_o = 1'b1;
                    end
                end else if (hit) begin
                    cpu_ack_o     = 1'b1;
                    plru_update_o = 1'b1;
                    state_d       = IDLE;
                end else begin
                    mem_start_o = 1'b1;
                    state_d     = REFILL;
                end
            end

            REFILL: begin
                if (mem_done_i) begin
                    state_d = INSTALL;
                end
            end

            // line lands in the victim way and the cpu gets its word
            INSTALL: begin
                wr_way_o      = victim_i;
                wr_tag_en_o   = 1'b1;
                wr_data_en_o  = 1'b1;
                wr_line_o     = mem_rdata_i;
                wr_sel_o      = '1;
                access_way_o  = victim_i;
                plru_update_o = 1'b1;
                cpu_ack_o     = 1'b1;
                cpu_rdata_o   = line_word(mem_rdata_i, req_offset);
                state_d       = IDLE;
            end

            WRITE_MEM: begin
                if (mem_done_i) begin
                    cpu_ack_o = 1'b1;
                    state_d   = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en_o) begin
            req_q <= cpu_req_i;  // held until the ack
        end
    end

    a_ack_single: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        cpu_ack_o |=> !cpu_ack_o
    );

endmodule

/* hdl/data_cache.sv */
`timescale 1ns/1ps

module data_cache
    import dcache_pkg::*;
#(
    parameter int unsigned NUM_SETS_LOG2 = 4,
    localparam int unsigned TAG_W = ADDR_W - OFFSET_W - NUM_SETS_LOG2
) (
    input  logic       clk_i,
    input  logic       rstn_i,

    // cpu bus
    input  logic       cpu_cyc_i,
    input  logic       cpu_stb_i,
    input  logic       cpu_we_i,
    input  addr_t      cpu_addr_i,
    input  word_sel_t  cpu_sel_i,
    input  word_t      cpu_wdata_i,
    output logic       cpu_ack_o,
    output word_t      cpu_rdata_o,

    // memory bus
    output logic       mem_cyc_o,
    output logic       mem_stb_o,
    output logic       mem_we_o,
    output line_addr_t mem_addr_o,
    output line_sel_t  mem_sel_o,
    output line_t      mem_wdata_o,
    input  logic       mem_ack_i,
    input  line_t      mem_rdata_i
);

    cpu_req_t                         cpu_req;

    logic                             rd_en;
    logic [NUM_SETS_LOG2-1:0]         rd_index;
    logic [NUM_WAYS-1:0][TAG_W-1:0]   rd_tags;
    logic [NUM_WAYS-1:0]              rd_valid;
    line_t [NUM_WAYS-1:0]             rd_lines;
    way_idx_t                         wr_way;
    logic                             wr_tag_en;
    logic                             wr_data_en;
    logic [NUM_SETS_LOG2-1:0]         wr_index;
    logic [TAG_W-1:0]                 wr_tag;
    line_t                            wr_line;
    line_sel_t                        wr_sel;

    logic [NUM_SETS_LOG2-1:0]         plru_index;
    way_idx_t                         access_way;
    logic                             plru_update;
    way_idx_t                         victim;

    logic                             mem_start;
    mem_req_t                         mem_req;
    logic                             mem_done;
    line_t                            mem_line;  // line returned by the port

    assign cpu_req = '{we: cpu_we_i, addr: cpu_addr_i, sel: cpu_sel_i, wdata: cpu_wdata_i};

    dcache_ctrl #(.NUM_SETS_LOG2(NUM_SETS_LOG2)) u_ctrl (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .cpu_cyc_i(cpu_cyc_i), .cpu_stb_i(cpu_stb_i), .cpu_req_i(cpu_req),
        .cpu_ack_o(cpu_ack_o), .cpu_rdata_o(cpu_rdata_o),
        .rd_en_o(rd_en), .rd_index_o(rd_index),
        .rd_tags_i(rd_tags), .rd_valid_i(rd_valid), .rd_lines_i(rd_lines),
        .wr_way_o(wr_way), .wr_tag_en_o(wr_tag_en), .wr_data_en_o(wr_data_en),
        .wr_index_o(wr_index), .wr_tag_o(wr_tag), .wr_line_o(wr_line), .wr_sel_o(wr_sel),
        .index_o(plru_index), .access_way_o(access_way), .plru_update_o(plru_update),
        .victim_i(victim),
        .mem_start_o(mem_start), .mem_req_o(mem_req),
        .mem_done_i(mem_done), .mem_rdata_i(mem_line)
    );

    dcache_way_store #(.NUM_SETS_LOG2(NUM_SETS_LOG2)) u_way_store (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .rd_en_i(rd_en), .rd_index_i(rd_index),
        .wr_way_i(wr_way), .wr_tag_en_i(wr_tag_en), .wr_data_en_i(wr_data_en),
        .wr_index_i(wr_index), .wr_tag_i(wr_tag), .wr_line_i(wr_line), .wr_sel_i(wr_sel),
        .rd_tags_o(rd_tags), .rd_valid_o(rd_valid), .rd_lines_o(rd_lines)
    );

    dcache_plru #(.NUM_SETS_LOG2(NUM_SETS_LOG2)) u_plru (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .index_i(plru_index), .access_way_i(access_way), .update_i(plru_update),
        .victim_o(victim)
    );

    dcache_mem_port u_mem_port (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .start_i(mem_start), .req_i(mem_req), .done_o(mem_done), .rdata_o(mem_line),
        .mem_cyc_o(mem_cyc_o), .mem_stb_o(mem_stb_o), .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o), .mem_sel_o(mem_sel_o), .mem_wdata_o(mem_wdata_o),
        .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
    );

endmodule

/* verification/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
    import dcache_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  line_addr_t  addr_i,
    input  line_sel_t   sel_i,
    input  line_t       wdata_i,
    input  logic [1:0]  delay_i,         // extra wait cycles for the next access
    output logic        ack_o,
    output line_t       rdata_o,
    output int unsigned read_count_o,
    output int unsigned write_count_o,
    output line_addr_t  last_wr_addr_o,
    output line_sel_t   last_wr_sel_o
);

    line_t      mem [line_addr_t];  // lines never written read as the fill pattern
    logic       busy_q;
    logic [1:0] wait_q;

    function automatic word_t fill_word(addr_t addr);
        return (addr * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    function automatic line_t read_line(line_addr_t laddr);
        line_t line;
        if (mem.exists(laddr)) begin
            return mem[laddr];
        end
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line[i*WORD_W +: WORD_W] = fill_word({laddr, OFFSET_W'(i)});
        end
        return line;
    endfunction

    always @(posedge clk_i) begin : serve
        line_t line;
        if (!rstn_i) begin
            ack_o          <= 1'b0;
            busy_q         <= 1'b0;
            wait_q         <= '0;
            rdata_o        <= '0;
            read_count_o   <= 0;
            write_count_o  <= 0;
            last_wr_addr_o <= '0;
            last_wr_sel_o  <= '0;
        end else begin
            ack_o <= 1'b0;
            if (cyc_i && stb_i && !ack_o) begin
                if (!busy_q) begin
                    busy_q <= 1'b1;
                    wait_q <= delay_i;
                end else if (wait_q != 0) begin
                    wait_q <= wait_q - 1'b1;
                end else begin
                    busy_q <= 1'b0;
                    ack_o  <= 1'b1;
                    line = read_line(addr_i);
                    if (we_i) begin
                        for (int b = 0; b < $bits(line_sel_t); b++) begin
                            if (sel_i[b]) begin
                                line[b*8 +: 8] = wdata_i[b*8 +: 8];
                            end
                        end
                        mem[addr_i] = line;
                        write_count_o  <= write_count_o + 1;
                        last_wr_addr_o <= addr_i;
                        last_wr_sel_o  <= sel_i;
                    end else begin
                        rdata_o      <= line;
                        read_count_o <= read_count_o + 1;
                    end
                end
            end
        end
    end

endmodule

/* verification/tb_data_cache.sv */
`timescale 1ns/1ps

module tb_data_cache
    import dcache_pkg::*;
();

    localparam int unsigned SETS_LOG2  = 4;
    localparam int unsigned TAG_W      = ADDR_W - OFFSET_W - SETS_LOG2;
    localparam int unsigned NUM_SETS   = 2**SETS_LOG2;
    localparam int unsigned MAX_CYCLES = 10000;  // about 700 accesses of up to 12 cycles
    localparam logic [31:0] SEED       = 32'hc74e131f;

    // what the cache must show when it acknowledges
    typedef struct packed {
        logic        we;
        word_t       rdata;
        int unsigned reads;
        int unsigned writes;
        line_addr_t  wr_addr;
        line_sel_t   wr_sel;
    } expect_t;

    logic        clk, rstn;
    logic        cpu_cyc, cpu_stb, cpu_we, cpu_ack;
    addr_t       cpu_addr;
    word_sel_t   cpu_sel;
    word_t       cpu_wdata, cpu_rdata;
    logic        mem_cyc, mem_stb, mem_we, mem_ack;
    line_addr_t  mem_addr, mem_last_addr;
    line_sel_t   mem_sel, mem_last_sel;
    line_t       mem_wdata, mem_rdata;
    logic [1:0]  mem_delay;
    int unsigned mem_reads, mem_writes;

    // reference cache state
    logic [TAG_W-1:0]    ref_tag   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] ref_valid [NUM_SETS];
    plru_t               ref_plru  [NUM_SETS];
    word_t               ref_mem   [addr_t];
    int unsigned         ref_reads, ref_writes;

    expect_t     exp_q [$];
    string       test_name;
    int unsigned checks, errors, test_errors, tests_run, tests_failed;
    int unsigned cycles = 0;
    logic [31:0] stim_state, delay_state;

    data_cache #(.NUM_SETS_LOG2(SETS_LOG2)) u_dut (
        .clk_i(clk), .rstn_i(rstn),
        .cpu_cyc_i(cpu_cyc), .cpu_stb_i(cpu_stb), .cpu_we_i(cpu_we), .cpu_addr_i(cpu_addr),
        .cpu_sel_i(cpu_sel), .cpu_wdata_i(cpu_wdata), .cpu_ack_o(cpu_ack),
        .cpu_rdata_o(cpu_rdata),
        .mem_cyc_o(mem_cyc), .mem_stb_o(mem_stb), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
        .mem_sel_o(mem_sel), .mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack),
        .mem_rdata_i(mem_rdata)
    );

    tb_mem_model u_mem (
        .clk_i(clk), .rstn_i(rstn), .cyc_i(mem_cyc), .stb_i(mem_stb), .we_i(mem_we),
        .addr_i(mem_addr), .sel_i(mem_sel), .wdata_i(mem_wdata), .delay_i(mem_delay),
        .ack_o(mem_ack), .rdata_o(mem_rdata), .read_count_o(mem_reads),
        .write_count_o(mem_writes), .last_wr_addr_o(mem_last_addr),
        .last_wr_sel_o(mem_last_sel)
    );

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic word_t fill_word(addr_t addr);
        return (addr * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    // one access on the model, returns the word a read must see
    function automatic word_t ref_access(logic we, addr_t addr, word_sel_t sel, word_t wdata);
        logic [SETS_LOG2-1:0] idx;
        logic [TAG_W-1:0]     tag;
        logic                 hit;
        way_idx_t             way;
        word_t                word;
        idx  = addr[OFFSET_W +: SETS_LOG2];
        tag  = addr[ADDR_W-1 -: TAG_W];
        hit  = 1'b0;
        way  = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = way_idx_t'(w);
            end
        end
        word = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) word[b*8 +: 8] = wdata[b*8 +: 8];
            end
            ref_mem[addr] = word;
            ref_writes++;  // write-through, no allocate
        end else if (!hit) begin
            way = ref_plru[idx][0] ? {1'b1, ref_plru[idx][2]} : {1'b0, ref_plru[idx][1]};
            ref_tag[idx][way]   = tag;
            ref_valid[idx][way] = 1'b1;
            ref_reads++;
        end
        if (hit || !we) begin
            ref_plru[idx][0] = ~way[1];
            if (way[1]) ref_plru[idx][2] = ~way[0];
            else        ref_plru[idx][1] = ~way[0];
        end
        return word;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_idle();
        checks++;
        assert (!cpu_ack && !mem_cyc && !mem_stb) else begin
            $display("ERROR %s: a bus is active before the first request", test_name);
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // called 2 ns after a rising edge, returns at the same point
    task automatic access(input logic we, input addr_t addr, input word_sel_t sel,
                          input word_t wdata);
        expect_t e;
        e.rdata   = ref_access(we, addr, sel, wdata);
        e.we      = we;
        e.reads   = ref_reads;
        e.writes  = ref_writes;
        e.wr_addr = addr[ADDR_W-1:OFFSET_W];
        e.wr_sel  = line_sel_t'(sel) << (4 * addr[OFFSET_W-1:0]);
        exp_q.push_back(e);
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_sel   = sel;
        cpu_wdata = wdata;
        @(negedge clk);
        while (!cpu_ack) @(negedge clk);
        @(posedge clk);
        #2;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        @(posedge clk);
        #2;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        #2;
        delay_state = xorshift(delay_state);
        mem_delay   = delay_state[1:0];  // 0 to 3 extra cycles before the memory ack
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // compare every cpu ack against the oldest expectation
    always @(negedge clk) begin : compare
        expect_t e;
        if (rstn && cpu_ack) begin
            if (exp_q.size() == 0) begin
                $display("ERROR %s: the cache acknowledged with no request pending", test_name);
                errors++;
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                if (!e.we) check_value("read data", e.rdata, cpu_rdata);
                check_value("memory reads", e.reads, mem_reads);
                check_value("memory writes", e.writes, mem_writes);
                if (e.we) begin
                    check_value("write line address", 32'(e.wr_addr), 32'(mem_last_addr));
                    check_value("write sel", 32'(e.wr_sel), 32'(mem_last_sel));
                end
            end
        end
    end

    initial begin : main
        logic [31:0] r;
        word_sel_t   sel;
        addr_t       addr;
        rstn        = 1'b0;
        cpu_cyc     = 1'b0;
        cpu_stb     = 1'b0;
        cpu_we      = 1'b0;
        cpu_addr    = '0;
        cpu_sel     = '0;
        cpu_wdata   = '0;
        mem_delay   = '0;
        stim_state  = SEED;
        delay_state = xorshift(SEED);
        ref_reads   = 0;
        ref_writes  = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_valid[s] = '0;
            ref_plru[s]  = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;

        start_test("reset_idle");
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #2;
        finish_test();

        start_test("read_miss_hit");
        access(1'b0, 32'h0000_0105, 4'hf, '0);  // refill
        access(1'b0, 32'h0000_0105, 4'hf, '0);
        access(1'b0, 32'h0000_0107, 4'hf, '0);
        finish_test();

        start_test("write_through");
        access(1'b1, 32'h0000_0105, 4'b0101, 32'hdead_beef);
        access(1'b0, 32'h0000_0105, 4'hf, '0);  // merged bytes, no refill
        access(1'b1, 32'h0000_0106, 4'b1000, 32'h1234_5678);
        access(1'b0, 32'h0000_0106, 4'hf, '0);
        finish_test();

        start_test("write_no_allocate");
        access(1'b1, 32'h0000_2208, 4'hf, 32'h0bad_cafe);
        access(1'b0, 32'h0000_2208, 4'hf, '0);
        finish_test();

        start_test("plru_eviction");
        for (int t = 1; t <= 5; t++) begin
            access(1'b0, addr_t'((t << 6) | (5 << 2)), 4'hf, '0);
        end
        // newest lines first, only the evicted one refills
        for (int t = 5; t >= 1; t--) begin
            access(1'b0, addr_t'((t << 6) | (5 << 2) | 1), 4'hf, '0);
        end
        finish_test();

        start_test("random_mix");
        repeat (600) begin
            stim_state = xorshift(stim_state);
            r          = stim_state;
            sel        = (r[7:4] == 0) ? 4'hf : r[7:4];
            addr       = {(r[20] ? 24'ha5c3c1 : 24'h0), r[9:8], 2'b00, r[1:0], r[3:2]};
            stim_state = xorshift(stim_state);
            access(r[12:10] < 3, addr, sel, stim_state);
        end
        finish_test();

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* list.f */
hdl/dcache_pkg.sv
hdl/dcache_way_store.sv
hdl/dcache_plru.sv
hdl/dcache_mem_port.sv
hdl/dcache_ctrl.sv
hdl/data_cache.sv
verification/tb_mem_model.sv
verification/tb_data_cache.sv
